// ==== all.f ====
common/bus_pkg.sv
xbar/xbar.sv
logic/clint.sv
logic/core_bus_top.sv
testbench/tb_axi_mem.sv
testbench/tb_core_bus.sv

// ==== Bender.yml ====
package:
  name: core_bus

sources:
  - files:
      - common/bus_pkg.sv
      - xbar/xbar.sv
      - logic/clint.sv
      - logic/core_bus_top.sv
  - target: test
    files:
      - testbench/tb_axi_mem.sv
      - testbench/tb_core_bus.sv

// ==== testbench/tb_core_bus.sv ====
`timescale 1ns/100ps

module tb_core_bus;

	localparam int          num_tests = 6;
	localparam int          hs_limit  = 60;
	localparam logic [31:0] data_mask = 32'h5a5a_0000;

	logic clock;
	logic rst_n;
	int   errors;

	bus_pkg::ifu_ar_t ifu_ar;
	logic             ifu_ar_valid;
	logic             ifu_ar_ready;
	bus_pkg::ifu_r_t  ifu_r;
	logic             ifu_r_valid;
	logic             ifu_r_ready;
	bus_pkg::lsu_ar_t lsu_ar;
	logic             lsu_ar_valid;
	logic             lsu_ar_ready;
	bus_pkg::lite_r_t lsu_r;
	logic             lsu_r_valid;
	logic             lsu_r_ready;
	bus_pkg::lsu_aw_t lsu_aw;
	logic             lsu_aw_valid;
	logic             lsu_aw_ready;
	bus_pkg::lsu_w_t  lsu_w;
	logic             lsu_w_valid;
	logic             lsu_w_ready;
	bus_pkg::lsu_b_t  lsu_b;
	logic             lsu_b_valid;
	logic             lsu_b_ready;
	bus_pkg::axi_ar_t m_ar;
	logic             m_ar_valid;
	logic             m_ar_ready;
	bus_pkg::axi_r_t  m_r;
	logic             m_r_valid;
	logic             m_r_ready;
	bus_pkg::axi_aw_t m_aw;
	logic             m_aw_valid;
	logic             m_aw_ready;
	bus_pkg::axi_w_t  m_w;
	logic             m_w_valid;
	logic             m_w_ready;
	bus_pkg::axi_b_t  m_b;
	logic             m_b_valid;
	logic             m_b_ready;

	// what the memory saw last
	bus_pkg::axi_ar_t mem_last_ar;
	int               mem_ar_count;
	bus_pkg::axi_aw_t mem_last_aw;
	bus_pkg::axi_w_t  mem_last_w;
	int               mem_aw_count;

	core_bus_top #(
		.clint_base(32'h0200_0000),
		.clint_size(32'h0001_0000)
	) core_bus_top_inst (.*);

	tb_axi_mem mem_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.ar       (m_ar),
		.ar_valid (m_ar_valid),
		.ar_ready (m_ar_ready),
		.r        (m_r),
		.r_valid  (m_r_valid),
		.r_ready  (m_r_ready),
		.aw       (m_aw),
		.aw_valid (m_aw_valid),
		.aw_ready (m_aw_ready),
		.w        (m_w),
		.w_valid  (m_w_valid),
		.w_ready  (m_w_ready),
		.b        (m_b),
		.b_valid  (m_b_valid),
		.b_ready  (m_b_ready),
		.last_ar  (mem_last_ar),
		.ar_count (mem_ar_count),
		.last_aw  (mem_last_aw),
		.last_w   (mem_last_w),
		.aw_count (mem_aw_count)
	);

	always #50 clock = ~clock;

	task automatic report_value(input string test, input string field,
		input logic [63:0] expected, input logic [63:0] actual);
		$display("ERROR %s: %s expected %0h actual %0h", test, field, expected, actual);
		errors++;
	endtask

	task automatic report_failure(input string test, input string what);
		$display("%s: %s", test, what);
		errors++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#10;
		end
	endtask

	task automatic lsu_read(input string test, input logic [31:0] addr,
		output bus_pkg::lite_r_t data, output time ar_time, output time r_time);
		int   n;
		logic seen;
		data         = '0;
		r_time       = 0;
		lsu_ar.addr  = addr;
		lsu_ar.size  = 3'd2;
		lsu_ar_valid = 1'b1;
		lsu_r_ready  = 1'b1;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < hs_limit) begin
			@(posedge clock);
			n++;
			seen = lsu_ar_ready;
		end
		ar_time = $time;
		#10;
		lsu_ar_valid = 1'b0;
		if (!seen) begin
			report_failure(test, "LSU read address was never accepted");
		end else begin
			n    = 0;
			seen = 1'b0;
			while (!seen && n < hs_limit) begin
				@(posedge clock);
				n++;
				seen = lsu_r_valid;
				data = lsu_r;
			end
			r_time = $time;
			#10;
			if (!seen)
				report_failure(test, "LSU read data never arrived");
		end
		lsu_r_ready = 1'b0;
	endtask

	// checks every beat against the memory data rule
	task automatic ifu_read(input string test, input logic [31:0] addr,
		input logic [3:0] len, output time ar_time);
		int              n;
		int              k;
		logic            seen;
		logic            done;
		bus_pkg::ifu_r_t beat;
		logic [31:0]     expected;
		ifu_ar.addr  = addr;
		ifu_ar.len   = len;
		ifu_ar.burst = bus_pkg::burst_incr;
		ifu_ar_valid = 1'b1;
		ifu_r_ready  = 1'b1;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < hs_limit) begin
			@(posedge clock);
			n++;
			seen = ifu_ar_ready;
		end
		ar_time = $time;
		#10;
		ifu_ar_valid = 1'b0;
		if (!seen) begin
			report_failure(test, "IFU read address was never accepted");
		end else begin
			k    = 0;
			n    = 0;
			done = 1'b0;
			while (!done && n < hs_limit) begin
				@(posedge clock);
				n++;
				if (ifu_r_valid) begin
					beat     = ifu_r;
					expected = (addr + 4 * k) ^ data_mask;
					if (beat.data !== expected)
						report_value(test, "IFU beat data", expected, beat.data);
					if (beat.resp !== bus_pkg::resp_okay)
						report_value(test, "IFU beat resp", bus_pkg::resp_okay, beat.resp);
					if (beat.last !== (k == len))
						report_value(test, "IFU beat last", (k == len), beat.last);
					done = beat.last;
					k++;
				end
			end
			#10;
			if (!done)
				report_failure(test, "IFU burst never ended with a last beat");
		end
		ifu_r_ready = 1'b0;
	endtask

	task automatic test_ifu_burst();
		string name;
		int    base;
		time   t;
		name = "test_ifu_burst";
		base = mem_ar_count;
		ifu_read(name, 32'h8000_0010, 4'd3, t);
		if (mem_ar_count != base + 1)
			report_failure(name, "memory did not see exactly one read address");
		if (mem_last_ar.addr !== 32'h8000_0010)
			report_value(name, "AR addr", 32'h8000_0010, mem_last_ar.addr);
		if (mem_last_ar.len !== 8'd3)
			report_value(name, "AR len", 8'd3, mem_last_ar.len);
		if (mem_last_ar.size !== 3'd2)
			report_value(name, "AR size", 3'd2, mem_last_ar.size);
		if (mem_last_ar.burst !== bus_pkg::burst_incr)
			report_value(name, "AR burst", bus_pkg::burst_incr, mem_last_ar.burst);
		if (mem_last_ar.id !== 4'd0)
			report_value(name, "AR id", 4'd0, mem_last_ar.id);
	endtask

	task automatic test_lsu_soc_read();
		string            name;
		int               base;
		bus_pkg::lite_r_t data;
		time              ta;
		time              tr;
		name = "test_lsu_soc_read";
		base = mem_ar_count;
		lsu_read(name, 32'h8000_0100, data, ta, tr);
		if (data.data !== (32'h8000_0100 ^ data_mask))
			report_value(name, "LSU data", 32'h8000_0100 ^ data_mask, data.data);
		if (data.resp !== bus_pkg::resp_okay)
			report_value(name, "LSU resp", bus_pkg::resp_okay, data.resp);
		if (mem_ar_count != base + 1)
			report_failure(name, "SoC read did not reach the memory once");
		if (mem_last_ar.len !== 8'd0)
			report_value(name, "AR len", 8'd0, mem_last_ar.len);
		if (mem_last_ar.size !== 3'd2)
			report_value(name, "AR size", 3'd2, mem_last_ar.size);
		if (mem_last_ar.burst !== 2'd0)
			report_value(name, "AR burst", 2'd0, mem_last_ar.burst);
		if (mem_last_ar.id !== 4'd0)
			report_value(name, "AR id", 4'd0, mem_last_ar.id);
	endtask

	task automatic test_clint_timer();
		string            name;
		int               base;
		bus_pkg::lite_r_t first;
		bus_pkg::lite_r_t second;
		bus_pkg::lite_r_t other;
		time              t1;
		time              t2;
		time              tr;
		logic [31:0]      cycles;
		name = "test_clint_timer";
		base = mem_ar_count;
		lsu_read(name, 32'h0200_bff8, first, t1, tr);
		idle_cycles(3);
		lsu_read(name, 32'h0200_bff8, second, t2, tr);
		cycles = (t2 - t1) / 100; // one mtime tick per period
		if (second.data - first.data !== cycles)
			report_value(name, "mtime delta", cycles, second.data - first.data);
		if (first.resp !== bus_pkg::resp_okay)
			report_value(name, "first mtime resp", bus_pkg::resp_okay, first.resp);
		if (second.resp !== bus_pkg::resp_okay)
			report_value(name, "second mtime resp", bus_pkg::resp_okay, second.resp);
		lsu_read(name, 32'h0200_bffc, other, t1, tr);
		if (other.data !== 32'd0)
			report_value(name, "mtime high word", 32'd0, other.data);
		if (other.resp !== bus_pkg::resp_okay)
			report_value(name, "mtime high resp", bus_pkg::resp_okay, other.resp);
		lsu_read(name, 32'h0200_0004, other, t1, tr);
		if (other.resp !== bus_pkg::resp_slverr)
			report_value(name, "bad offset resp", bus_pkg::resp_slverr, other.resp);
		if (other.data !== 32'd0)
			report_value(name, "bad offset data", 32'd0, other.data);
		if (mem_ar_count != base)
			report_failure(name, "a CLINT read reached the external memory");
	endtask

	task automatic test_arbitration();
		string            name;
		bus_pkg::lite_r_t data;
		time              lsu_ar_time;
		time              lsu_r_time;
		time              ifu_ar_time;
		name = "test_arbitration";
		fork
			lsu_read(name, 32'h8000_0040, data, lsu_ar_time, lsu_r_time);
			ifu_read(name, 32'h8000_0080, 4'd1, ifu_ar_time);
		join
		if (data.data !== (32'h8000_0040 ^ data_mask))
			report_value(name, "LSU data", 32'h8000_0040 ^ data_mask, data.data);
		if (ifu_ar_time <= lsu_r_time)
			report_failure(name, "IFU was served before the LSU read completed");
	endtask

	task automatic test_lsu_write();
		string           name;
		int              base;
		int              n;
		logic            aw_done;
		logic            w_done;
		logic            b_done;
		bus_pkg::lsu_b_t resp;
		name         = "test_lsu_write";
		base         = mem_aw_count;
		resp         = '0;
		lsu_aw.addr  = 32'h8000_0200;
		lsu_aw.size  = 3'd2;
		lsu_w.data   = 32'hc0de_1234;
		lsu_w.strb   = 4'b0110;
		lsu_aw_valid = 1'b1;
		lsu_w_valid  = 1'b1;
		lsu_b_ready  = 1'b1;
		aw_done = 1'b0;
		w_done  = 1'b0;
		b_done  = 1'b0;
		n       = 0;
		while (!b_done && n < hs_limit) begin
			@(posedge clock);
			n++;
			if (lsu_aw_valid && lsu_aw_ready)
				aw_done = 1'b1;
			if (lsu_w_valid && lsu_w_ready)
				w_done = 1'b1;
			if (lsu_b_valid && lsu_b_ready) begin
				b_done = 1'b1;
				resp   = lsu_b;
			end
			#10;
			if (aw_done)
				lsu_aw_valid = 1'b0;
			if (w_done)
				lsu_w_valid = 1'b0;
		end
		lsu_b_ready = 1'b0;
		if (!aw_done || !w_done || !b_done) begin
			report_failure(name, "write handshakes did not all complete");
		end else begin
			if (mem_aw_count != base + 1)
				report_failure(name, "memory did not see exactly one write address");
			if (mem_last_aw.addr !== 32'h8000_0200)
				report_value(name, "AW addr", 32'h8000_0200, mem_last_aw.addr);
			if (mem_last_aw.len !== 8'd0)
				report_value(name, "AW len", 8'd0, mem_last_aw.len);
			if (mem_last_aw.size !== 3'd2)
				report_value(name, "AW size", 3'd2, mem_last_aw.size);
			if (mem_last_aw.burst !== 2'd0)
				report_value(name, "AW burst", 2'd0, mem_last_aw.burst);
			if (mem_last_aw.id !== 4'd0)
				report_value(name, "AW id", 4'd0, mem_last_aw.id);
			if (mem_last_w.data !== 32'hc0de_1234)
				report_value(name, "W data", 32'hc0de_1234, mem_last_w.data);
			if (mem_last_w.strb !== 4'b0110)
				report_value(name, "W strb", 4'b0110, mem_last_w.strb);
			if (mem_last_w.last !== 1'b1)
				report_value(name, "W last", 1'b1, mem_last_w.last);
			if (resp.resp !== bus_pkg::resp_okay)
				report_value(name, "B resp", bus_pkg::resp_okay, resp.resp);
		end
	endtask

	task automatic test_backpressure();
		string            name;
		int               n;
		logic             seen;
		bus_pkg::lite_r_t held;
		time              r_time;
		time              ifu_time;
		name         = "test_backpressure";
		held         = '0;
		r_time       = 0;
		lsu_ar.addr  = 32'h8000_0300;
		lsu_ar.size  = 3'd2;
		lsu_ar_valid = 1'b1;
		lsu_r_ready  = 1'b0;
		fork
			begin
				n    = 0;
				seen = 1'b0;
				while (!seen && n < hs_limit) begin
					@(posedge clock);
					n++;
					seen = lsu_ar_ready;
				end
				#10;
				lsu_ar_valid = 1'b0;
				if (!seen)
					report_failure(name, "LSU read address was never accepted");
				n    = 0;
				seen = 1'b0;
				while (!seen && n < hs_limit) begin
					@(posedge clock);
					n++;
					seen = lsu_r_valid;
					held = lsu_r;
				end
				if (!seen)
					report_failure(name, "LSU read data never arrived");
				repeat (4) begin // r_ready held low
					@(posedge clock);
					if (!lsu_r_valid)
						report_failure(name, "r_valid dropped while r_ready was low");
					if (lsu_r !== held)
						report_value(name, "held LSU data", held, lsu_r);
					if (ifu_ar_ready)
						report_failure(name, "IFU address accepted while the LSU owned the bus");
				end
				#10;
				lsu_r_ready = 1'b1;
				@(posedge clock);
				r_time = $time;
				#10;
				lsu_r_ready = 1'b0;
			end
			begin
				@(posedge clock);
				#10;
				ifu_read(name, 32'h8000_0400, 4'd0, ifu_time);
			end
		join
		if (held.data !== (32'h8000_0300 ^ data_mask))
			report_value(name, "LSU data", 32'h8000_0300 ^ data_mask, held.data);
		if (ifu_time <= r_time)
			report_failure(name, "IFU was granted before the LSU beat was accepted");
	endtask

	initial begin
		clock        = 1'b0;
		rst_n        = 1'b0;
		errors       = 0;
		ifu_ar       = '0;
		ifu_ar_valid = 1'b0;
		ifu_r_ready  = 1'b0;
		lsu_ar       = '0;
		lsu_ar_valid = 1'b0;
		lsu_r_ready  = 1'b0;
		lsu_aw       = '0;
		lsu_aw_valid = 1'b0;
		lsu_w        = '0;
		lsu_w_valid  = 1'b0;
		lsu_b_ready  = 1'b0;
		repeat (3) @(posedge clock);
		#10;
		rst_n = 1'b1;
		idle_cycles(2);
		test_ifu_burst();
		test_lsu_soc_read();
		test_clint_timer();
		test_arbitration();
		test_lsu_write();
		test_backpressure();
		idle_cycles(2);
		$display("%0d errors over %0d tests", errors, num_tests);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		repeat (num_tests * 200 + 100) @(posedge clock);
		$display("watchdog: run hung, %0d errors counted before the stop", errors);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== testbench/tb_axi_mem.sv ====
`timescale 1ns/100ps

module tb_axi_mem #(
	parameter logic [31:0] seed = 32'hafbf_b8d9
) (
	input  logic             clock,
	input  logic             rst_n,
	input  bus_pkg::axi_ar_t ar,
	input  logic             ar_valid,
	output logic             ar_ready,
	output bus_pkg::axi_r_t  r,
	output logic             r_valid,
	input  logic             r_ready,
	input  bus_pkg::axi_aw_t aw,
	input  logic             aw_valid,
	output logic             aw_ready,
	input  bus_pkg::axi_w_t  w,
	input  logic             w_valid,
	output logic             w_ready,
	output bus_pkg::axi_b_t  b,
	output logic             b_valid,
	input  logic             b_ready,
	output bus_pkg::axi_ar_t last_ar,
	output int               ar_count,
	output bus_pkg::axi_aw_t last_aw,
	output bus_pkg::axi_w_t  last_w,
	output int               aw_count
);

	localparam logic [31:0] data_mask = 32'h5a5a_0000;

	logic [31:0] rd_lfsr;
	logic [31:0] wr_lfsr;

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_delay(inout logic [31:0] s, output int d);
		d = 0;
		repeat (2) begin
			d = d * 2 + s[0]; // one step per bit
			s = lfsr_step(s);
		end
	endtask

	task automatic skip_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#10;
		end
	endtask

	initial begin : read_side
		bus_pkg::axi_ar_t req;
		int               d;
		int               k;
		rd_lfsr  = seed;
		ar_ready = 1'b0;
		r_valid  = 1'b0;
		r        = '0;
		last_ar  = '0;
		ar_count = 0;
		forever begin
			@(posedge clock);
			if (rst_n && ar_valid) begin
				#10;
				draw_delay(rd_lfsr, d);
				skip_cycles(d);
				ar_ready = 1'b1;
				do @(posedge clock); while (!ar_valid);
				req     = ar;
				last_ar = req;
				ar_count++;
				#10;
				ar_ready = 1'b0;
				for (k = 0; k <= req.len; k++) begin
					draw_delay(rd_lfsr, d);
					skip_cycles(d);
					r.data  = (req.addr + 4 * k) ^ data_mask; // incrementing beat address
					r.resp  = bus_pkg::resp_okay;
					r.last  = (k == req.len);
					r.id    = req.id;
					r_valid = 1'b1;
					do @(posedge clock); while (!r_ready);
					#10;
					r_valid = 1'b0;
				end
			end
		end
	end

	// aw, then w, then b
	initial begin : write_side
		int d;
		wr_lfsr  = seed;
		aw_ready = 1'b0;
		w_ready  = 1'b0;
		b_valid  = 1'b0;
		b        = '0;
		last_aw  = '0;
		last_w   = '0;
		aw_count = 0;
		forever begin
			@(posedge clock);
			if (rst_n && aw_valid) begin
				#10;
				draw_delay(wr_lfsr, d);
				skip_cycles(d);
				aw_ready = 1'b1;
				do @(posedge clock); while (!aw_valid);
				last_aw = aw;
				aw_count++;
				#10;
				aw_ready = 1'b0;
				draw_delay(wr_lfsr, d);
				skip_cycles(d);
				w_ready = 1'b1;
				do @(posedge clock); while (!w_valid);
				last_w = w;
				#10;
				w_ready = 1'b0;
				draw_delay(wr_lfsr, d);
				skip_cycles(d);
				b.resp  = bus_pkg::resp_okay;
				b.id    = last_aw.id;
				b_valid = 1'b1;
				do @(posedge clock); while (!b_ready);
				#10;
				b_valid = 1'b0;
			end
		end
	end

endmodule

// ==== logic/core_bus_top.sv ====
`timescale 1ns/100ps

module core_bus_top #(
	parameter logic [31:0] clint_base = 32'h0200_0000,
	parameter logic [31:0] clint_size = 32'h0001_0000
) (
	input  logic             clock,
	input  logic             rst_n,

	input  bus_pkg::ifu_ar_t ifu_ar,
	input  logic             ifu_ar_valid,
	output logic             ifu_ar_ready,
	output bus_pkg::ifu_r_t  ifu_r,
	output logic             ifu_r_valid,
	input  logic             ifu_r_ready,

	input  bus_pkg::lsu_ar_t lsu_ar,
	input  logic             lsu_ar_valid,
	output logic             lsu_ar_ready,
	output bus_pkg::lite_r_t lsu_r,
	output logic             lsu_r_valid,
	input  logic             lsu_r_ready,

	input  bus_pkg::lsu_aw_t lsu_aw,
	input  logic             lsu_aw_valid,
	output logic             lsu_aw_ready,
	input  bus_pkg::lsu_w_t  lsu_w,
	input  logic             lsu_w_valid,
	output logic             lsu_w_ready,
	output bus_pkg::lsu_b_t  lsu_b,
	output logic             lsu_b_valid,
	input  logic             lsu_b_ready,

	output bus_pkg::axi_ar_t m_ar,
	output logic             m_ar_valid,
	input  logic             m_ar_ready,
	input  bus_pkg::axi_r_t  m_r,
	input  logic             m_r_valid,
	output logic             m_r_ready,
	output bus_pkg::axi_aw_t m_aw,
	output logic             m_aw_valid,
	input  logic             m_aw_ready,
	output bus_pkg::axi_w_t  m_w,
	output logic             m_w_valid,
	input  logic             m_w_ready,
	input  bus_pkg::axi_b_t  m_b,
	input  logic             m_b_valid,
	output logic             m_b_ready
);

	// crossbar to timer
	bus_pkg::lite_ar_t clint_ar;
	logic              clint_ar_valid;
	logic              clint_ar_ready;
	bus_pkg::lite_r_t  clint_r;
	logic              clint_r_valid;
	logic              clint_r_ready;

	xbar #(
		.clint_base(clint_base),
		.clint_size(clint_size)
	) xbar_inst (
		.clock          (clock),
		.rst_n          (rst_n),
		.ifu_ar         (ifu_ar),
		.ifu_ar_valid   (ifu_ar_valid),
		.ifu_ar_ready   (ifu_ar_ready),
		.ifu_r          (ifu_r),
		.ifu_r_valid    (ifu_r_valid),
		.ifu_r_ready    (ifu_r_ready),
		.lsu_ar         (lsu_ar),
		.lsu_ar_valid   (lsu_ar_valid),
		.lsu_ar_ready   (lsu_ar_ready),
		.lsu_r          (lsu_r),
		.lsu_r_valid    (lsu_r_valid),
		.lsu_r_ready    (lsu_r_ready),
		.lsu_aw         (lsu_aw),
		.lsu_aw_valid   (lsu_aw_valid),
		.lsu_aw_ready   (lsu_aw_ready),
		.lsu_w          (lsu_w),
		.lsu_w_valid    (lsu_w_valid),
		.lsu_w_ready    (lsu_w_ready),
		.lsu_b          (lsu_b),
		.lsu_b_valid    (lsu_b_valid),
		.lsu_b_ready    (lsu_b_ready),
		.m_ar           (m_ar),
		.m_ar_valid     (m_ar_valid),
		.m_ar_ready     (m_ar_ready),
		.m_r            (m_r),
		.m_r_valid      (m_r_valid),
		.m_r_ready      (m_r_ready),
		.m_aw           (m_aw),
		.m_aw_valid     (m_aw_valid),
		.m_aw_ready     (m_aw_ready),
		.m_w            (m_w),
		.m_w_valid      (m_w_valid),
		.m_w_ready      (m_w_ready),
		.m_b            (m_b),
		.m_b_valid      (m_b_valid),
		.m_b_ready      (m_b_ready),
		.clint_ar       (clint_ar),
		.clint_ar_valid (clint_ar_valid),
		.clint_ar_ready (clint_ar_ready),
		.clint_r        (clint_r),
		.clint_r_valid  (clint_r_valid),
		.clint_r_ready  (clint_r_ready)
	);

	clint clint_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.ar       (clint_ar),
		.ar_valid (clint_ar_valid),
		.ar_ready (clint_ar_ready),
		.r        (clint_r),
		.r_valid  (clint_r_valid),
		.r_ready  (clint_r_ready)
	);

endmodule

// ==== logic/clint.sv ====
`timescale 1ns/100ps

module clint (
	input  logic              clock,
	input  logic              rst_n,

	input  bus_pkg::lite_ar_t ar,
	input  logic              ar_valid,
	output logic              ar_ready,

	output bus_pkg::lite_r_t  r,
	output logic              r_valid,
	input  logic              r_ready
);

	localparam logic [15:0] mtime_lo_off = 16'hbff8;
	localparam logic [15:0] mtime_hi_off = 16'hbffc;

	logic [63:0] mtime;
	logic [15:0] offset;
	logic        ar_fire;
	logic [31:0] rd_data;
	logic [1:0]  rd_resp;

	// free-running machine timer
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			mtime <= 64'd0;
		else
			mtime <= mtime + 64'd1;
	end

	assign offset   = ar.addr[15:0]; // window base is decoded upstream
	assign ar_ready = ~r_valid;
	assign ar_fire  = ar_valid & ar_ready;

	always_comb begin
		case (offset)
			mtime_lo_off: begin
				rd_data = mtime[31:0];
				rd_resp = bus_pkg::resp_okay;
			end
			mtime_hi_off: begin
				rd_data = mtime[63:32];
				rd_resp = bus_pkg::resp_okay;
			end
			default: begin
				rd_data = 32'd0;
				rd_resp = bus_pkg::resp_slverr;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			r_valid <= 1'b0;
		else if (ar_fire)
			r_valid <= 1'b1;
		else if (r_ready)
			r_valid <= 1'b0; // beat taken
	end

	// response payload held until accepted
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			r.data <= rd_data;
			r.resp <= rd_resp;
		end
	end

endmodule

// ==== xbar/xbar.sv ====
`timescale 1ns/100ps

module xbar #(
	parameter logic [31:0] clint_base = 32'h0200_0000,
	parameter logic [31:0] clint_size = 32'h0001_0000
) (
	input  logic              clock,
	input  logic              rst_n,

	input  bus_pkg::ifu_ar_t  ifu_ar,
	input  logic              ifu_ar_valid,
	output logic              ifu_ar_ready,
	output bus_pkg::ifu_r_t   ifu_r,
	output logic              ifu_r_valid,
	input  logic              ifu_r_ready,

	input  bus_pkg::lsu_ar_t  lsu_ar,
	input  logic              lsu_ar_valid,
	output logic              lsu_ar_ready,
	output bus_pkg::lite_r_t  lsu_r,
	output logic              lsu_r_valid,
	input  logic              lsu_r_ready,

	input  bus_pkg::lsu_aw_t  lsu_aw,
	input  logic              lsu_aw_valid,
	output logic              lsu_aw_ready,
	input  bus_pkg::lsu_w_t   lsu_w,
	input  logic              lsu_w_valid,
	output logic              lsu_w_ready,
	output bus_pkg::lsu_b_t   lsu_b,
	output logic              lsu_b_valid,
	input  logic              lsu_b_ready,

	output bus_pkg::axi_ar_t  m_ar,
	output logic              m_ar_valid,
	input  logic              m_ar_ready,
	input  bus_pkg::axi_r_t   m_r,
	input  logic              m_r_valid,
	output logic              m_r_ready,
	output bus_pkg::axi_aw_t  m_aw,
	output logic              m_aw_valid,
	input  logic              m_aw_ready,
	output bus_pkg::axi_w_t   m_w,
	output logic              m_w_valid,
	input  logic              m_w_ready,
	input  bus_pkg::axi_b_t   m_b,
	input  logic              m_b_valid,
	output logic              m_b_ready,

	output bus_pkg::lite_ar_t clint_ar,
	output logic              clint_ar_valid,
	input  logic              clint_ar_ready,
	input  bus_pkg::lite_r_t  clint_r,
	input  logic              clint_r_valid,
	output logic              clint_r_ready
);

	logic ifu_reading;
	logic lsu_reading;
	logic lsu_to_clint; // target latched with the grant
	logic idle;
	logic lsu_grant;
	logic ifu_grant;
	logic ifu_done;
	logic lsu_done;
	logic lsu_hit_clint;
	logic lsu_soc;
	logic lsu_clint;

	assign lsu_hit_clint = (lsu_ar.addr >= clint_base) &&
		(lsu_ar.addr < clint_base + clint_size);

	assign idle      = ~ifu_reading & ~lsu_reading;
	assign lsu_grant = idle & lsu_ar_valid; // lsu has priority
	assign ifu_grant = idle & ~lsu_ar_valid & ifu_ar_valid;
	assign ifu_done  = ifu_r_valid & ifu_r_ready & ifu_r.last;
	assign lsu_done  = lsu_r_valid & lsu_r_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ifu_reading  <= 1'b0;
			lsu_reading  <= 1'b0;
			lsu_to_clint <= 1'b0;
		end else begin
			ifu_reading <= ifu_grant | (ifu_reading & ~ifu_done);
			lsu_reading <= lsu_grant | (lsu_reading & ~lsu_done);
			if (lsu_grant)
				lsu_to_clint <= lsu_hit_clint;
		end
	end

	assign lsu_soc   = lsu_reading & ~lsu_to_clint;
	assign lsu_clint = lsu_reading & lsu_to_clint;

	// read address toward the owner's target
	always_comb begin
		m_ar = '0; // id stays 0
		if (ifu_reading) begin
			m_ar.addr  = ifu_ar.addr;
			m_ar.len   = {4'd0, ifu_ar.len};
			m_ar.size  = 3'd2;
			m_ar.burst = ifu_ar.burst;
		end else if (lsu_soc) begin
			m_ar.addr = lsu_ar.addr;
			m_ar.size = lsu_ar.size; // single beat with len and burst 0
		end
	end

	always_comb begin
		clint_ar = '0;
		if (lsu_clint)
			clint_ar.addr = lsu_ar.addr;
	end

	assign m_ar_valid     = (ifu_reading & ifu_ar_valid) | (lsu_soc & lsu_ar_valid);
	assign clint_ar_valid = lsu_clint & lsu_ar_valid;
	assign ifu_ar_ready   = ifu_reading & m_ar_ready;
	assign lsu_ar_ready   = (lsu_soc & m_ar_ready) | (lsu_clint & clint_ar_ready);

	// read data back to the owner
	assign m_r_ready     = (ifu_reading & ifu_r_ready) | (lsu_soc & lsu_r_ready);
	assign clint_r_ready = lsu_clint & lsu_r_ready;
	assign ifu_r_valid   = ifu_reading & m_r_valid;
	assign lsu_r_valid   = (lsu_soc & m_r_valid) | (lsu_clint & clint_r_valid);

	always_comb begin
		ifu_r = '0;
		if (ifu_reading) begin
			ifu_r.data = m_r.data;
			ifu_r.resp = m_r.resp;
			ifu_r.last = m_r.last;
		end
	end

	always_comb begin
		lsu_r = '0;
		if (lsu_soc) begin
			lsu_r.data = m_r.data;
			lsu_r.resp = m_r.resp;
		end else if (lsu_clint) begin
			lsu_r = clint_r;
		end
	end

	// writes go straight out as single beats
	always_comb begin
		m_aw       = '0;
		m_aw.addr  = lsu_aw.addr;
		m_aw.size  = lsu_aw.size;
		m_w.data   = lsu_w.data;
		m_w.strb   = lsu_w.strb;
		m_w.last   = lsu_w_valid; // every beat is the last
		lsu_b.resp = m_b.resp;
	end

	assign m_aw_valid   = lsu_aw_valid;
	assign lsu_aw_ready = m_aw_ready;
	assign m_w_valid    = lsu_w_valid;
	assign lsu_w_ready  = m_w_ready;
	assign lsu_b_valid  = m_b_valid;
	assign m_b_ready    = lsu_b_ready;

endmodule

// ==== common/bus_pkg.sv ====
package bus_pkg;

	localparam logic [1:0] resp_okay   = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;
	localparam logic [1:0] burst_incr  = 2'd1;

	// external AXI4 master channels
	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  id;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
		logic [3:0]  id;
	} axi_r_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  id;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
	} axi_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
		logic        last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
		logic [3:0] id;
	} axi_b_t;

	// core side
	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  len;
		logic [1:0]  burst;
	} ifu_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
	} ifu_r_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} lsu_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} lite_r_t;

	typedef struct packed {
		logic [31:0] addr;
	} lite_ar_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} lsu_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} lsu_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} lsu_b_t;

endpackage
